//--- source/aluOpPkg.sv
package aluOpPkg;

    // ============================================================
    // Data path sizes
    // ============================================================
    localparam int WIDTH       = 32;              // ALU word width
    localparam int SHAMT_WIDTH = $clog2(WIDTH);   // Low bits of b used as shift amount

    // ============================================================
    // Opcodes
    // ============================================================
    typedef enum logic [2:0] {
        ADD = 3'd0,   // a + b
        SUB = 3'd1,   // a - b
        AND = 3'd2,   // Bitwise and
        OR  = 3'd3,   // Bitwise or
        XOR = 3'd4,   // Bitwise xor
        SLL = 3'd5,   // Logical left shift
        SRL = 3'd6,   // Logical right shift
        SRA = 3'd7    // Arithmetic right shift
    } aluOp_t;

    // Shift direction and fill for the serial shifter
    typedef enum logic [1:0] {
        SHIFT_LEFT        = 2'd0,   // Zero fill from bit 0
        SHIFT_RIGHT_LOGIC = 2'd1,   // Zero fill from MSB
        SHIFT_RIGHT_ARITH = 2'd2    // Sign fill from MSB
    } shiftKind_t;

endpackage

//--- source/aluCtrlPkg.sv
package aluCtrlPkg;

    // ============================================================
    // Controller FSM
    // ============================================================
    typedef enum logic [2:0] {
        IDLE         = 3'd0,   // Waiting for req
        EXEC         = 3'd1,   // One cycle of compute or shifter kick-off
        SHIFT        = 3'd2,   // Waiting on serial shifter done
        ACK          = 3'd3,   // Holding result, ack up while req high
        WAIT_REQ_LOW = 3'd4    // ack dropped, back to idle next
    } ctrlState_t;

    // ============================================================
    // Shift counter
    // ============================================================
    // One spare bit over the shift amount so the counter can hold 32
    // if the word ever grows, and zero detection stays simple
    localparam int COUNT_WIDTH = 6;

endpackage

//--- source/aluOpIf.sv
`timescale 1ns/1ps

interface aluOpIf
    import aluOpPkg::*;
();

    // ============================================================
    // Operands from the controller latches
    // ============================================================
    logic [WIDTH-1:0] opA;         // Latched operand a
    logic [WIDTH-1:0] opB;         // Latched operand b
    aluOp_t           op;          // Latched opcode

    // ============================================================
    // Combinational ALU outputs
    // ============================================================
    logic [WIDTH-1:0] aluResult;   // Add, sub or logic result
    logic             aluCarry;    // Adder carry, zero for logic ops

    // Controller side
    modport ctrl (
        output opA,
        output opB,
        output op,
        input  aluResult,
        input  aluCarry
    );

    // Integer ALU side
    modport exec (
        input  opA,
        input  opB,
        input  op,
        output aluResult,
        output aluCarry
    );

endinterface

//--- source/shiftIf.sv
`timescale 1ns/1ps

interface shiftIf
    import aluOpPkg::*;
();

    logic                   start;     // One-cycle kick from controller
    logic [WIDTH-1:0]       value;     // Word to shift
    logic [SHAMT_WIDTH-1:0] amount;    // Bits to shift, 0..31
    shiftKind_t             kind;      // Direction and fill
    logic                   done;      // One-cycle finish pulse
    logic [WIDTH-1:0]       shifted;   // Valid from done until next start

    // Controller side
    modport ctrl (
        output start,
        output value,
        output amount,
        output kind,
        input  done,
        input  shifted
    );

    // Sequencer side
    modport seq (
        input  start,
        input  value,
        input  amount,
        input  kind,
        output done,
        output shifted
    );

endinterface

//--- source/claAdder.sv
`timescale 1ns/1ps

module claAdder
    import aluOpPkg::*;
(
    input  logic [WIDTH-1:0] a,       // Operand a
    input  logic [WIDTH-1:0] b,       // Operand b
    input  logic             subEn,   // Subtract a - b
    output logic [WIDTH-1:0] sum,     // Sum or difference
    output logic             cout     // Final carry, no borrow for sub
);

    logic [WIDTH-1:0] finalB;   // b, inverted for subtract
    logic [WIDTH-1:0] p;        // Per-bit propagate
    logic [WIDTH-1:0] g;        // Per-bit generate
    logic [WIDTH:0]   c;        // Carry into each bit

    // ============================================================
    // Two's complement subtract setup
    // ============================================================
    assign finalB = subEn ? ~b : b;   // Invert b for a + ~b + 1
    assign c[0]   = subEn;            // The +1 of the negate

    // ============================================================
    // Propagate, generate, carry and sum per bit
    // ============================================================
    genvar i;
    generate
        for (i = 0; i < WIDTH; i++) begin : genBit
            assign p[i]   = a[i] ^ finalB[i];      // Half-sum doubles as propagate
            assign g[i]   = a[i] & finalB[i];      // Both set, carry out regardless
            assign c[i+1] = g[i] | (p[i] & c[i]);  // Lookahead term for next bit
            assign sum[i] = p[i] ^ c[i];           // Full-adder sum
        end
    endgenerate

    assign cout = c[WIDTH];   // Bit 32 of a + b, or a >= b for sub

endmodule

//--- source/integerAlu.sv
`timescale 1ns/1ps

module integerAlu
    import aluOpPkg::*;
(
    aluOpIf.exec opBus   // Operands in, result and carry out
);

    logic             subEn;     // Adder in subtract mode
    logic [WIDTH-1:0] addSum;    // Adder output
    logic             addCout;   // Adder carry out
    logic [WIDTH-1:0] andRes;    // Bitwise and
    logic [WIDTH-1:0] orRes;     // Bitwise or
    logic [WIDTH-1:0] xorRes;    // Bitwise xor

    // ============================================================
    // Adder
    // ============================================================
    assign subEn = (opBus.op == SUB);   // Only SUB flips the adder

    claAdder adder0 (
        .a     (opBus.opA),
        .b     (opBus.opB),
        .subEn (subEn),
        .sum   (addSum),
        .cout  (addCout)
    );

    // ============================================================
    // Logic unit
    // ============================================================
    assign andRes = opBus.opA & opBus.opB;
    assign orRes  = opBus.opA | opBus.opB;
    assign xorRes = opBus.opA ^ opBus.opB;

    // ============================================================
    // Result select
    // ============================================================
    always_comb begin
        opBus.aluResult = '0;     // Shifts come from the sequencer
        opBus.aluCarry  = 1'b0;   // Carry only for add and sub
        case (opBus.op)
            ADD, SUB: begin
                opBus.aluResult = addSum;
                opBus.aluCarry  = addCout;
            end
            AND: begin
                opBus.aluResult = andRes;
            end
            OR: begin
                opBus.aluResult = orRes;
            end
            XOR: begin
                opBus.aluResult = xorRes;
            end
            default: begin
                // SLL, SRL, SRA handled serially
                opBus.aluResult = '0;
            end
        endcase
    end

endmodule

//--- source/shiftSequencer.sv
`timescale 1ns/1ps

module shiftSequencer
    import aluOpPkg::*;
    import aluCtrlPkg::*;
(
    input  logic clk,       // System clock
    input  logic rst,       // Sync reset, active high
    shiftIf.seq  shiftBus   // Start, operands, done, shifted word
);

    logic [WIDTH-1:0]       valueReg;   // Word being shifted
    logic [COUNT_WIDTH-1:0] count;      // Bits still to shift
    shiftKind_t             kindReg;    // Kind captured at start
    logic                   busy;       // Run in progress
    logic                   countZero;  // No bits left

    assign countZero = (count == '0);

    // ============================================================
    // Control: counter and busy flag
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (shiftBus.start) begin
            busy  <= 1'b1;
            count <= COUNT_WIDTH'(shiftBus.amount);   // Zero-extend amount
        end else if (busy) begin
            if (countZero) begin
                busy <= 1'b0;             // done seen this cycle
            end else begin
                count <= count - 1'b1;    // One bit per cycle
            end
        end
    end

    // ============================================================
    // Data: value register
    // ============================================================
    always_ff @(posedge clk) begin
        if (shiftBus.start) begin
            valueReg <= shiftBus.value;
            kindReg  <= shiftBus.kind;
        end else if (busy && !countZero) begin
            case (kindReg)
                SHIFT_LEFT:        valueReg <= {valueReg[WIDTH-2:0], 1'b0};
                SHIFT_RIGHT_LOGIC: valueReg <= {1'b0, valueReg[WIDTH-1:1]};
                SHIFT_RIGHT_ARITH: valueReg <= {valueReg[WIDTH-1], valueReg[WIDTH-1:1]};
                default:           valueReg <= valueReg;   // Unused encoding holds
            endcase
        end
    end

    // Pulse in the cycle the count sits at zero, busy drops after it
    assign shiftBus.done    = busy && countZero;
    assign shiftBus.shifted = valueReg;   // Stable once done, until next start

endmodule

//--- source/aluController.sv
`timescale 1ns/1ps

module aluController
    import aluOpPkg::*;
    import aluCtrlPkg::*;
(
    input  logic             clk,      // System clock
    input  logic             rst,      // Sync reset, active high
    input  logic             req,      // Host request
    input  aluOp_t           op,       // Host opcode
    input  logic [WIDTH-1:0] a,        // Host operand a
    input  logic [WIDTH-1:0] b,        // Host operand b
    output logic             ack,      // Result valid, held until req low
    output logic [WIDTH-1:0] result,   // Registered result
    output logic             carry,    // Registered carry flag
    aluOpIf.ctrl             opBus,    // To integer ALU
    shiftIf.ctrl             shiftBus  // To serial shifter
);

    ctrlState_t       state;       // FSM state
    aluOp_t           opReg;       // Latched opcode
    logic [WIDTH-1:0] aReg;        // Latched operand a
    logic [WIDTH-1:0] bReg;        // Latched operand b
    logic             isShiftOp;   // Latched op goes to the shifter
    shiftKind_t       kindSel;     // Shifter kind for latched op

    // ============================================================
    // Operand latches
    // ============================================================
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin   // Host may change inputs after this
            opReg <= op;
            aReg  <= a;
            bReg  <= b;
        end
    end

    assign isShiftOp = (opReg == SLL) || (opReg == SRL) || (opReg == SRA);

    always_comb begin
        case (opReg)
            SLL:     kindSel = SHIFT_LEFT;
            SRA:     kindSel = SHIFT_RIGHT_ARITH;
            default: kindSel = SHIFT_RIGHT_LOGIC;
        endcase
    end

    // ============================================================
    // Dispatch to the execution units
    // ============================================================
    assign opBus.opA = aReg;
    assign opBus.opB = bReg;
    assign opBus.op  = opReg;

    assign shiftBus.start  = (state == EXEC) && isShiftOp;   // EXEC is one cycle
    assign shiftBus.value  = aReg;
    assign shiftBus.amount = bReg[SHAMT_WIDTH-1:0];           // b mod 32
    assign shiftBus.kind   = kindSel;

    // ============================================================
    // Handshake FSM
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            ack    <= 1'b0;
            result <= '0;
            carry  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (isShiftOp) begin
                        state <= SHIFT;            // Variable latency path
                    end else begin
                        result <= opBus.aluResult;
                        carry  <= opBus.aluCarry;
                        state  <= ACK;
                    end
                end
                SHIFT: begin
                    if (shiftBus.done) begin
                        result <= shiftBus.shifted;
                        carry  <= 1'b0;            // No carry out of shifts
                        state  <= ACK;
                    end
                end
                ACK: begin
                    if (req) begin
                        ack <= 1'b1;               // Raise and hold
                    end else begin
                        ack   <= 1'b0;             // Host released req
                        state <= WAIT_REQ_LOW;
                    end
                end
                WAIT_REQ_LOW: begin
                    state <= IDLE;                 // ack already low here
                end
                default: begin
                    state <= IDLE;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- source/aluTop.sv
`timescale 1ns/1ps

module aluTop
    import aluOpPkg::*;
(
    input  logic             clk,      // System clock
    input  logic             rst,      // Sync reset, active high
    input  logic             req,      // Host request
    input  aluOp_t           op,       // Operation select
    input  logic [WIDTH-1:0] a,        // Operand a
    input  logic [WIDTH-1:0] b,        // Operand b
    output logic             ack,      // Handshake acknowledge
    output logic [WIDTH-1:0] result,   // Operation result
    output logic             carry     // Adder carry, 0 otherwise
);

    // ============================================================
    // Internal buses
    // ============================================================
    aluOpIf opBus ();      // Controller to integer ALU
    shiftIf shiftBus ();   // Controller to serial shifter

    // ============================================================
    // Units
    // ============================================================
    aluController ctrl0 (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .op       (op),
        .a        (a),
        .b        (b),
        .ack      (ack),
        .result   (result),
        .carry    (carry),
        .opBus    (opBus.ctrl),
        .shiftBus (shiftBus.ctrl)
    );

    integerAlu alu0 (
        .opBus (opBus.exec)
    );

    shiftSequencer shift0 (
        .clk      (clk),
        .rst      (rst),
        .shiftBus (shiftBus.seq)
    );

endmodule

//--- dv/aluTb_sva.sv
`timescale 1ns/1ps

module aluTb_sva
    import aluOpPkg::*;
(
    input logic             clk,      // DUT clock
    input logic             rst,      // DUT reset
    input logic             req,      // Host request
    input logic             ack,      // DUT acknowledge
    input logic [WIDTH-1:0] result,   // Registered result
    input logic             carry     // Registered carry
);

    int failCount = 0;   // Assertion failures so far

    // ============================================================
    // Handshake rules
    // ============================================================
    ackOnlyAfterReq: assert property (@(posedge clk) disable iff (rst)
        (!req && !ack) |=> !ack)
        else begin
            $error("ack rose while req was low");
            failCount++;
        end

    ackHeldWhileReq: assert property (@(posedge clk) disable iff (rst)
        (ack && req) |=> ack)
        else begin
            $error("ack dropped before req went low");
            failCount++;
        end

    // Outputs frozen for the whole ack phase
    resultStable: assert property (@(posedge clk) disable iff (rst)
        ack |=> ($stable(result) && $stable(carry)))
        else begin
            $error("result or carry changed while ack was high");
            failCount++;
        end

    ackLowInReset: assert property (@(posedge clk) rst |=> !ack)
        else begin
            $error("ack high during reset");
            failCount++;
        end

endmodule

bind aluTop aluTb_sva sva0 (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .ack    (ack),
    .result (result),
    .carry  (carry)
);

//--- dv/aluTb.sv
`timescale 1ns/1ps

module aluTb
    import aluOpPkg::*;
();

    localparam int ACK_TIMEOUT = 100;   // Cycles, longest shift is about 35

    logic             clk;
    logic             rst;
    logic             req;
    aluOp_t           op;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic             ack;
    logic [WIDTH-1:0] result;
    logic             carry;

    logic [15:0]      lfsr;           // Random generator state
    logic [WIDTH-1:0] expResQ[$];     // Expected results, in issue order
    logic             expCarryQ[$];   // Expected carries
    logic [WIDTH-1:0] expRes;         // Expected for the current ack phase
    logic             expCarry;
    logic             inAck;          // ack already seen high
    int               issued;
    int               checked;

    aluTop dut0 (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .op     (op),
        .a      (a),
        .b      (b),
        .ack    (ack),
        .result (result),
        .carry  (carry)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;   // 20 ns period

    // ============================================================
    // Helpers
    // ============================================================
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];   // x^16 + x^14 + x^13 + x^11
        return {s[14:0], fb};
    endfunction

    task automatic takeBits(input int n, output logic [WIDTH-1:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);              // One step per bit
            val  = {val[WIDTH-2:0], lfsr[0]};
        end
    endtask

    // Returns {carry, result}
    function automatic logic [WIDTH:0] refAlu(input aluOp_t f, input logic [WIDTH-1:0] x,
                                              input logic [WIDTH-1:0] y);
        logic [4:0] sh;
        sh = y[4:0];   // Amount is b mod 32
        case (f)
            ADD:     return {1'b0, x} + {1'b0, y};
            SUB:     return {(x >= y), x - y};   // Carry means no borrow
            AND:     return {1'b0, x & y};
            OR:      return {1'b0, x | y};
            XOR:     return {1'b0, x ^ y};
            SLL:     return {1'b0, x << sh};
            SRL:     return {1'b0, x >> sh};
            default: return {1'b0, $signed(x) >>> sh};
        endcase
    endfunction

    task automatic abortRun();
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkValue(input string name, input logic [WIDTH-1:0] got,
                              input logic [WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abortRun();
        end
    endtask

    // ============================================================
    // Host side of the four-phase handshake
    // ============================================================
    task automatic runTxn(input aluOp_t f, input logic [WIDTH-1:0] x,
                          input logic [WIDTH-1:0] y, input int extraHold);
        logic [WIDTH:0]   expVal;
        logic [WIDTH-1:0] holdBits;
        int               waited;
        expVal = refAlu(f, x, y);
        expResQ.push_back(expVal[WIDTH-1:0]);
        expCarryQ.push_back(expVal[WIDTH]);
        issued++;
        op  = f;
        a   = x;
        b   = y;
        req = 1'b1;
        waited = 0;
        while (!ack && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!ack) begin
            $display("Timed out waiting for ack to rise");
            abortRun();
        end
        a  = ~x;                 // Operands already latched
        b  = ~y;
        op = aluOp_t'(~f);
        takeBits(2, holdBits);   // Extra 0 to 3 cycles of req
        repeat (holdBits + extraHold) begin
            @(posedge clk);
            #2;
        end
        req = 1'b0;
        waited = 0;
        while (ack && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (ack) begin
            $display("Timed out waiting for ack to fall after req dropped");
            abortRun();
        end
    endtask

    // ============================================================
    // Compare on the falling edge, every cycle of the ack phase
    // ============================================================
    always @(negedge clk) begin
        if (dut0.sva0.failCount != 0) begin
            $display("A handshake or output stability assertion failed");
            abortRun();
        end else if (rst) begin
            inAck = 1'b0;
        end else if (ack) begin
            if (!inAck && expResQ.size() == 0) begin
                $display("ack rose with no transaction outstanding");
                abortRun();
            end else begin
                if (!inAck) begin
                    expRes   = expResQ.pop_front();
                    expCarry = expCarryQ.pop_front();
                    checked++;
                end
                inAck = 1'b1;
                checkValue("result", result, expRes);   // Also catches drift under hold
                checkValue("carry", {{(WIDTH-1){1'b0}}, carry}, {{(WIDTH-1){1'b0}}, expCarry});
            end
        end else begin
            inAck = 1'b0;
        end
    end

    initial begin
        logic [WIDTH-1:0] rOp;
        logic [WIDTH-1:0] rA;
        logic [WIDTH-1:0] rB;
        rst     = 1'b1;
        req     = 1'b0;
        op      = ADD;
        a       = '0;
        b       = '0;
        lfsr    = 16'd25009;
        issued  = 0;
        checked = 0;
        inAck   = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        checkValue("ack", {{(WIDTH-1){1'b0}}, ack}, '0);
        checkValue("result", result, '0);
        checkValue("carry", {{(WIDTH-1){1'b0}}, carry}, '0);
        rst = 1'b0;
        @(posedge clk);
        #2;
        // Add and subtract edge cases
        runTxn(ADD, 32'hffff_ffff, 32'h0000_0001, 0);
        runTxn(ADD, 32'h8000_0000, 32'h8000_0000, 0);
        runTxn(ADD, 32'h1234_5678, 32'h0f0f_0f0f, 0);
        runTxn(SUB, 32'h0000_0005, 32'h0000_0005, 0);
        runTxn(SUB, 32'h0000_0003, 32'h0000_0005, 0);
        runTxn(SUB, 32'hdead_beef, 32'h0000_0003, 0);
        runTxn(AND, 32'hf0f0_a5a5, 32'hff00_0ff0, 0);
        runTxn(OR,  32'hf0f0_a5a5, 32'hff00_0ff0, 0);
        runTxn(XOR, 32'hf0f0_a5a5, 32'hff00_0ff0, 0);
        // Shifts at 0, 1, 31 and amounts wrapped mod 32
        runTxn(SLL, 32'h8000_0001, 32'd0, 0);
        runTxn(SLL, 32'h8000_0001, 32'd1, 0);
        runTxn(SLL, 32'h8000_0001, 32'd31, 0);
        runTxn(SLL, 32'h0000_00ff, 32'd35, 0);
        runTxn(SRL, 32'h8000_0001, 32'd0, 0);
        runTxn(SRL, 32'h8000_0001, 32'd1, 0);
        runTxn(SRL, 32'h8000_0001, 32'd31, 0);
        runTxn(SRL, 32'hff00_0000, 32'hffff_ffe4, 0);
        runTxn(SRA, 32'h8000_0000, 32'd0, 0);
        runTxn(SRA, 32'h8000_0000, 32'd1, 0);
        runTxn(SRA, 32'h8000_0000, 32'd31, 0);
        runTxn(SRA, 32'hf000_0000, 32'd35, 0);
        runTxn(SRA, 32'h7000_0000, 32'd31, 0);
        // Long hold on req, then a follow-up transaction
        runTxn(ADD, 32'h0000_ffff, 32'h0000_0001, 6);
        runTxn(SUB, 32'h0000_0001, 32'h0000_0002, 0);
        for (int n = 0; n < 300; n++) begin
            takeBits(3, rOp);
            takeBits(WIDTH, rA);
            takeBits(WIDTH, rB);
            runTxn(aluOp_t'(rOp[2:0]), rA, rB, 0);
        end
        @(posedge clk);
        #2;
        if (dut0.sva0.failCount != 0) begin
            $display("A handshake or output stability assertion failed");
            abortRun();
        end else if (checked != issued || expResQ.size() != 0) begin
            $display("Not every transaction produced a checked result");
            abortRun();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- build.f
source/aluOpPkg.sv
source/aluCtrlPkg.sv
source/aluOpIf.sv
source/shiftIf.sv
source/claAdder.sv
source/integerAlu.sv
source/shiftSequencer.sv
source/aluController.sv
source/aluTop.sv
dv/aluTb_sva.sv
dv/aluTb.sv
